//--- Bender.yml
package:
  name: pcie_host_interface

sources:
  - include_dirs:
      - .
    files:
      - host_if_pkg.sv
      - host_target_router.sv
      - ppfifo_mem_writer.sv
      - ppfifo_mem_reader.sv
      - word_mem.sv
      - dma_read_tracker.sv
      - pcie_host_interface.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pcie_host_interface.sv

//--- all.f
+incdir+.
host_if_pkg.sv
host_target_router.sv
ppfifo_mem_writer.sv
ppfifo_mem_reader.sv
word_mem.sv
dma_read_tracker.sv
pcie_host_interface.sv
tb_pcie_host_interface.sv

//--- dma_read_tracker.sv
/*
  DMA read tracker
  counts DMA egress strobes and flags read finish at the word count
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module dma_read_tracker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_en,
  input  logic [`HOST_DATA_W-1:0] i_count,
  input  logic                    i_stb,
  output logic                    o_fin
);

  logic [`HOST_DATA_W-1:0] cnt;
  logic [`HOST_DATA_W-1:0] cnt_nxt;

  // strobes past the count are ignored
  assign cnt_nxt = (i_stb && (cnt < i_count)) ? cnt + 1'b1 : cnt;

  always_ff @(posedge clk) begin
    if (rst || !i_en) begin
      cnt   <= '0;
      o_fin <= 1'b0;
    end else begin
      cnt   <= cnt_nxt;
      o_fin <= (cnt_nxt >= i_count);
    end
  end

endmodule

//--- host_if_consts.svh
/*
  host interface constants
  widths shared by the transfer router, the memory target and the DMA tracker
*/

`ifndef HOST_IF_CONSTS_SVH
`define HOST_IF_CONSTS_SVH

// data word carried by every ping-pong buffer
`define HOST_DATA_W 32

// size field reported with each ping-pong buffer
`define HOST_FIFO_SIZE_W 24

// on-chip word memory, 256 words
`define HOST_MEM_AW 8

// number of egress buffers on the host side
`define HOST_EGR_CH 2

`endif

//--- host_if_pkg.sv
/*
  host interface types
  transfer request and ping-pong FIFO signal groups
*/

`include "host_if_consts.svh"

package host_if_pkg;

  // transfer destination
  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_MEM  = 2'd1,
    TGT_DMA  = 2'd2
  } target_e;

  // host transfer request
  typedef struct packed {
    target_e                  target;
    logic                     wr;
    logic                     rd;
    logic [`HOST_DATA_W-1:0]  addr;   // start word address
    logic [`HOST_DATA_W-1:0]  count;  // words to move
  } xfer_req_t;

  // ingress, from the side holding the data
  typedef struct packed {
    logic                         rdy;
    logic [`HOST_FIFO_SIZE_W-1:0] size;
    logic [`HOST_DATA_W-1:0]      data;
  } ing_src_t;

  // ingress, from the consumer
  typedef struct packed {
    logic act;
    logic stb;
  } ing_ctl_t;

  // egress, from the buffer owner
  typedef struct packed {
    logic [`HOST_EGR_CH-1:0]      rdy;
    logic [`HOST_FIFO_SIZE_W-1:0] size;
  } egr_sink_t;

  // egress, from the producer
  typedef struct packed {
    logic [`HOST_EGR_CH-1:0] act;
    logic                    stb;
    logic [`HOST_DATA_W-1:0] data;
  } egr_src_t;

endpackage

//--- host_target_router.sv
/*
  host target router
  steers the host ping-pong FIFOs to the memory or DMA target
  and picks the write and read finish flags for the active target
*/

`timescale 1ns/1ps

module host_target_router (
  input  host_if_pkg::xfer_req_t i_req,

  input  host_if_pkg::ing_src_t  i_host_ing,
  output host_if_pkg::ing_ctl_t  o_host_ing,
  input  host_if_pkg::egr_sink_t i_host_egr,
  output host_if_pkg::egr_src_t  o_host_egr,

  output host_if_pkg::ing_src_t  o_mem_ing,
  input  host_if_pkg::ing_ctl_t  i_mem_ing,
  output host_if_pkg::egr_sink_t o_mem_egr,
  input  host_if_pkg::egr_src_t  i_mem_egr,

  output host_if_pkg::ing_src_t  o_dma_ing,
  input  host_if_pkg::ing_ctl_t  i_dma_ing,
  output host_if_pkg::egr_sink_t o_dma_egr,
  input  host_if_pkg::egr_src_t  i_dma_egr,

  output logic                   o_mem_wr_en,
  output logic                   o_mem_rd_en,
  output logic                   o_dma_rd_en,

  input  logic                   i_mem_wr_fin,
  input  logic                   i_mem_rd_fin,
  input  logic                   i_dma_idle,
  input  logic                   i_dma_rd_fin,

  output logic                   o_write_fin,
  output logic                   o_read_fin
);

  logic mem_wr_sel;
  logic mem_rd_sel;
  logic dma_wr_sel;
  logic dma_rd_sel;

  // target and direction decode
  assign mem_wr_sel = (i_req.target == host_if_pkg::TGT_MEM) && i_req.wr;
  assign mem_rd_sel = (i_req.target == host_if_pkg::TGT_MEM) && i_req.rd;
  assign dma_wr_sel = (i_req.target == host_if_pkg::TGT_DMA) && i_req.wr;
  assign dma_rd_sel = (i_req.target == host_if_pkg::TGT_DMA) && i_req.rd;

  assign o_mem_wr_en = mem_wr_sel;
  assign o_mem_rd_en = mem_rd_sel;
  assign o_dma_rd_en = dma_rd_sel;

  // unselected targets see an idle, all-zero FIFO
  assign o_mem_ing = mem_wr_sel ? i_host_ing : '0;
  assign o_dma_ing = dma_wr_sel ? i_host_ing : '0;
  assign o_mem_egr = mem_rd_sel ? i_host_egr : '0;
  assign o_dma_egr = dma_rd_sel ? i_host_egr : '0;

  // handshake back to the host
  assign o_host_ing = mem_wr_sel ? i_mem_ing :
                      dma_wr_sel ? i_dma_ing : '0;
  assign o_host_egr = mem_rd_sel ? i_mem_egr :
                      dma_rd_sel ? i_dma_egr : '0;

  // DMA writes are done once the engine reports idle
  assign o_write_fin = mem_wr_sel ? i_mem_wr_fin :
                       dma_wr_sel ? i_dma_idle   : 1'b0;
  assign o_read_fin  = mem_rd_sel ? i_mem_rd_fin :
                       dma_rd_sel ? i_dma_rd_fin : 1'b0;

endmodule

//--- pcie_host_interface.sv
/*
  PCIe host interface
  routes host transfers to the on-chip word memory or to an external DMA engine
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module pcie_host_interface (
  input  logic                   clk,
  input  logic                   rst,
  input  host_if_pkg::xfer_req_t i_req,
  input  host_if_pkg::ing_src_t  i_host_ing,
  output host_if_pkg::ing_ctl_t  o_host_ing,
  input  host_if_pkg::egr_sink_t i_host_egr,
  output host_if_pkg::egr_src_t  o_host_egr,
  output host_if_pkg::ing_src_t  o_dma_ing,
  input  host_if_pkg::ing_ctl_t  i_dma_ing,
  output host_if_pkg::egr_sink_t o_dma_egr,
  input  host_if_pkg::egr_src_t  i_dma_egr,
  input  logic                   i_dma_idle,
  output logic                   o_write_fin,
  output logic                   o_read_fin
);

  host_if_pkg::ing_src_t   mem_ing_src;
  host_if_pkg::ing_ctl_t   mem_ing_ctl;
  host_if_pkg::egr_sink_t  mem_egr_sink;
  host_if_pkg::egr_src_t   mem_egr_src;

  logic                    mem_wr_en;
  logic                    mem_rd_en;
  logic                    dma_rd_en;
  logic                    mem_wr_fin;
  logic                    mem_rd_fin;
  logic                    dma_rd_fin;

  logic                    ram_wr_en;
  logic [`HOST_MEM_AW-1:0] ram_wr_addr;
  logic [`HOST_DATA_W-1:0] ram_wr_data;
  logic [`HOST_MEM_AW-1:0] ram_rd_addr;
  logic [`HOST_DATA_W-1:0] ram_rd_data;

  host_target_router u_router (
    .i_req        (i_req),
    .i_host_ing   (i_host_ing),
    .o_host_ing   (o_host_ing),
    .i_host_egr   (i_host_egr),
    .o_host_egr   (o_host_egr),
    .o_mem_ing    (mem_ing_src),
    .i_mem_ing    (mem_ing_ctl),
    .o_mem_egr    (mem_egr_sink),
    .i_mem_egr    (mem_egr_src),
    .o_dma_ing    (o_dma_ing),
    .i_dma_ing    (i_dma_ing),
    .o_dma_egr    (o_dma_egr),
    .i_dma_egr    (i_dma_egr),
    .o_mem_wr_en  (mem_wr_en),
    .o_mem_rd_en  (mem_rd_en),
    .o_dma_rd_en  (dma_rd_en),
    .i_mem_wr_fin (mem_wr_fin),
    .i_mem_rd_fin (mem_rd_fin),
    .i_dma_idle   (i_dma_idle),
    .i_dma_rd_fin (dma_rd_fin),
    .o_write_fin  (o_write_fin),
    .o_read_fin   (o_read_fin)
  );

  // low address bits index the word memory directly
  ppfifo_mem_writer u_writer (
    .clk       (clk),
    .rst       (rst),
    .i_en      (mem_wr_en),
    .i_base    (i_req.addr[`HOST_MEM_AW-1:0]),
    .i_count   (i_req.count),
    .i_ing     (mem_ing_src),
    .o_ing     (mem_ing_ctl),
    .o_wr_en   (ram_wr_en),
    .o_wr_addr (ram_wr_addr),
    .o_wr_data (ram_wr_data),
    .o_fin     (mem_wr_fin)
  );

  ppfifo_mem_reader u_reader (
    .clk       (clk),
    .rst       (rst),
    .i_en      (mem_rd_en),
    .i_base    (i_req.addr[`HOST_MEM_AW-1:0]),
    .i_count   (i_req.count),
    .i_egr     (mem_egr_sink),
    .o_egr     (mem_egr_src),
    .o_rd_addr (ram_rd_addr),
    .i_rd_data (ram_rd_data),
    .o_fin     (mem_rd_fin)
  );

  word_mem u_mem (
    .clk       (clk),
    .i_wr_en   (ram_wr_en),
    .i_wr_addr (ram_wr_addr),
    .i_wr_data (ram_wr_data),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (ram_rd_data)
  );

  dma_read_tracker u_tracker (
    .clk     (clk),
    .rst     (rst),
    .i_en    (dma_rd_en),
    .i_count (i_req.count),
    .i_stb   (i_dma_egr.stb),
    .o_fin   (dma_rd_fin)
  );

endmodule

//--- ppfifo_mem_reader.sv
/*
  memory to ping-pong egress reader
  fills free host egress buffers from the word memory until the word count is met
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module ppfifo_mem_reader (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_en,
  input  logic [`HOST_MEM_AW-1:0]      i_base,
  input  logic [`HOST_DATA_W-1:0]      i_count,
  input  host_if_pkg::egr_sink_t       i_egr,
  output host_if_pkg::egr_src_t        o_egr,
  output logic [`HOST_MEM_AW-1:0]      o_rd_addr,
  input  logic [`HOST_DATA_W-1:0]      i_rd_data,
  output logic                         o_fin
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_DONE
  } state_e;

  state_e                       state;
  logic [`HOST_EGR_CH-1:0]      act;
  logic [`HOST_EGR_CH-1:0]      act_pick;
  logic                         issue;
  logic                         stb;
  logic [`HOST_FIFO_SIZE_W-1:0] iss_cnt;
  logic [`HOST_FIFO_SIZE_W-1:0] stb_cnt;
  logic [`HOST_FIFO_SIZE_W-1:0] buf_len;
  logic [`HOST_DATA_W-1:0]      total;
  logic [`HOST_DATA_W-1:0]      remaining;
  logic [`HOST_DATA_W-1:0]      size_ext;

  assign remaining = i_count - total;
  assign size_ext  = {{(`HOST_DATA_W - `HOST_FIFO_SIZE_W){1'b0}}, i_egr.size};

  // lowest set ready bit wins
  assign act_pick = i_egr.rdy & (~i_egr.rdy + 1'b1);

  // address goes out one cycle ahead of its strobe
  assign issue     = (state == ST_BURST) && (iss_cnt != buf_len);
  assign o_rd_addr = i_base + total[`HOST_MEM_AW-1:0];

  assign o_egr.act  = act;
  assign o_egr.stb  = stb;
  assign o_egr.data = i_rd_data;
  assign o_fin      = (state == ST_DONE) && (act == '0);

  always_ff @(posedge clk) begin
    if (rst || !i_en) begin
      state   <= ST_IDLE;
      act     <= '0;
      stb     <= 1'b0;
      iss_cnt <= '0;
      stb_cnt <= '0;
      buf_len <= '0;
      total   <= '0;
    end else begin
      stb <= issue;
      if (issue) begin
        iss_cnt <= iss_cnt + 1'b1;
        total   <= total + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (total >= i_count) begin
            state <= ST_DONE;
          end else if ((i_egr.rdy != '0) && (i_egr.size != '0)) begin
            act     <= act_pick;
            iss_cnt <= '0;
            stb_cnt <= '0;
            buf_len <= (remaining < size_ext) ? remaining[`HOST_FIFO_SIZE_W-1:0] : i_egr.size;
            state   <= ST_BURST;
          end
        end
        ST_BURST: begin
          if (stb) begin
            stb_cnt <= stb_cnt + 1'b1;
            // last word of this buffer, hand it back to the host
            if ((stb_cnt + 1'b1) == buf_len) begin
              act   <= '0;
              state <= (total == i_count) ? ST_DONE : ST_IDLE;
            end
          end
        end
        default: begin
          state <= ST_DONE;
        end
      endcase
    end
  end

endmodule

//--- ppfifo_mem_writer.sv
/*
  ping-pong ingress to memory writer
  drains host ingress buffers into the word memory until the word count is met
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module ppfifo_mem_writer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_en,
  input  logic [`HOST_MEM_AW-1:0]      i_base,
  input  logic [`HOST_DATA_W-1:0]      i_count,
  input  host_if_pkg::ing_src_t        i_ing,
  output host_if_pkg::ing_ctl_t        o_ing,
  output logic                         o_wr_en,
  output logic [`HOST_MEM_AW-1:0]      o_wr_addr,
  output logic [`HOST_DATA_W-1:0]      o_wr_data,
  output logic                         o_fin
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_DONE
  } state_e;

  state_e                       state;
  logic                         act;
  logic [`HOST_FIFO_SIZE_W-1:0] buf_cnt;
  logic [`HOST_FIFO_SIZE_W-1:0] buf_len;
  logic [`HOST_DATA_W-1:0]      total;
  logic [`HOST_DATA_W-1:0]      remaining;
  logic [`HOST_DATA_W-1:0]      size_ext;

  assign remaining = i_count - total;
  assign size_ext  = {{(`HOST_DATA_W - `HOST_FIFO_SIZE_W){1'b0}}, i_ing.size};

  // every cycle of a burst pops one word
  assign o_ing.act = act;
  assign o_ing.stb = act;

  assign o_wr_en   = act;
  assign o_wr_addr = i_base + total[`HOST_MEM_AW-1:0];
  assign o_wr_data = i_ing.data;
  assign o_fin     = (state == ST_DONE);

  always_ff @(posedge clk) begin
    if (rst || !i_en) begin
      state   <= ST_IDLE;
      act     <= 1'b0;
      buf_cnt <= '0;
      buf_len <= '0;
      total   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (total >= i_count) begin
            state <= ST_DONE;
          end else if (i_ing.rdy && (i_ing.size != '0)) begin
            // take the smaller of buffer size and words left
            act     <= 1'b1;
            buf_cnt <= '0;
            buf_len <= (remaining < size_ext) ? remaining[`HOST_FIFO_SIZE_W-1:0] : i_ing.size;
            state   <= ST_BURST;
          end
        end
        ST_BURST: begin
          buf_cnt <= buf_cnt + 1'b1;
          total   <= total + 1'b1;
          if ((buf_cnt + 1'b1) == buf_len) begin
            act   <= 1'b0;
            state <= ((total + 1'b1) == i_count) ? ST_DONE : ST_IDLE;
          end
        end
        default: begin
          // finish holds until enable drops
          state <= ST_DONE;
        end
      endcase
    end
  end

endmodule

//--- tb_pcie_host_interface.sv
/*
  testbench for the PCIe host interface
  host and DMA models, memory shadow, egress word compare and report
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module tb_pcie_host_interface;

  localparam int TIMEOUT  = 2000;
  localparam int N_WORDS  = 20;
  localparam int BASE     = 16;
  localparam int ING_SIZE = 8;
  localparam int EGR_SIZE = 6;
  localparam int DMA_CNT  = 9;

  logic                    clk;
  logic                    rst;
  host_if_pkg::xfer_req_t  req;
  host_if_pkg::ing_src_t   host_ing;
  host_if_pkg::ing_ctl_t   host_ing_ctl;
  host_if_pkg::egr_sink_t  host_egr;
  host_if_pkg::egr_src_t   host_egr_src;
  host_if_pkg::ing_src_t   dma_ing_src;
  host_if_pkg::ing_ctl_t   dma_ing;
  host_if_pkg::egr_sink_t  dma_egr_sink;
  host_if_pkg::egr_src_t   dma_egr;
  logic                    dma_idle;
  logic                    write_fin;
  logic                    read_fin;

  logic [15:0]             lfsr;
  logic [`HOST_DATA_W-1:0] shadow [1 << `HOST_MEM_AW];
  string                   cur_test;
  int                      errors;
  int                      tests;
  int                      failed;
  logic                    cmp_en;
  int                      cmp_idx;
  int                      buf_words [`HOST_EGR_CH];

  pcie_host_interface u_pcie_host_interface (
    .clk         (clk),
    .rst         (rst),
    .i_req       (req),
    .i_host_ing  (host_ing),
    .o_host_ing  (host_ing_ctl),
    .i_host_egr  (host_egr),
    .o_host_egr  (host_egr_src),
    .o_dma_ing   (dma_ing_src),
    .i_dma_ing   (dma_ing),
    .o_dma_egr   (dma_egr_sink),
    .i_dma_egr   (dma_egr),
    .i_dma_idle  (dma_idle),
    .o_write_fin (write_fin),
    .o_read_fin  (read_fin)
  );

  always #10 clk = ~clk;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // expected memory word at an address
  function automatic logic [`HOST_DATA_W-1:0] expected_word(input int addr);
    return shadow[addr % (1 << `HOST_MEM_AW)];
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic close_test(input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s passed", cur_test);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", cur_test, errors - err0);
    end
  endtask

  task automatic return_to_idle();
    @(negedge clk);
    req      = '0;
    host_ing = '0;
    host_egr = '0;
    dma_ing  = '0;
    dma_egr  = '0;
    dma_idle = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // egress words in order against the shadow memory
  always @(negedge clk) begin
    if (!cmp_en) begin
      cmp_idx = 0;
      for (int ch = 0; ch < `HOST_EGR_CH; ch++) begin
        buf_words[ch] = 0;
      end
    end else begin
      if (read_fin && cmp_idx != N_WORDS) begin
        report_fault("read finish is high before the last word");
      end
      if (host_egr_src.stb) begin
        if (host_egr_src.act == '0) begin
          report_fault("egress strobe seen with no buffer active");
        end
        if (host_egr_src.data !== expected_word(BASE + cmp_idx)) begin
          report_mismatch($sformatf("word %0d", cmp_idx), expected_word(BASE + cmp_idx),
                          host_egr_src.data);
        end
        cmp_idx++;
        for (int ch = 0; ch < `HOST_EGR_CH; ch++) begin
          if (host_egr_src.act[ch]) begin
            buf_words[ch]++;
            if (buf_words[ch] > EGR_SIZE) begin
              report_fault("egress buffer received more words than its size");
            end
          end
        end
      end
      for (int ch = 0; ch < `HOST_EGR_CH; ch++) begin
        if (!host_egr_src.act[ch]) begin
          buf_words[ch] = 0;
        end
      end
    end
  end

  task automatic check_reset_state();
    int          err0;
    logic [31:0] r;
    err0     = errors;
    cur_test = "reset_state";
    // every side busy while no target is selected
    take_random(32, r);
    host_ing = '{rdy: 1'b1, size: ING_SIZE, data: r};
    host_egr = '{rdy: '1, size: EGR_SIZE};
    dma_ing  = '{act: 1'b1, stb: 1'b1};
    take_random(32, r);
    dma_egr  = '{act: '1, stb: 1'b1, data: r};
    dma_idle = 1'b1;
    @(negedge clk);
    if (host_ing_ctl !== '0) report_mismatch("ingress act/stb", 0, host_ing_ctl);
    if (host_egr_src.act !== '0) report_mismatch("egress act", 0, host_egr_src.act);
    if (host_egr_src.stb !== 1'b0) report_mismatch("egress stb", 0, host_egr_src.stb);
    if (write_fin !== 1'b0) report_mismatch("write finish", 0, write_fin);
    if (read_fin !== 1'b0) report_mismatch("read finish", 0, read_fin);
    if (dma_ing_src !== '0) report_mismatch("dma ingress", 0, dma_ing_src);
    if (dma_egr_sink !== '0) report_mismatch("dma egress", 0, dma_egr_sink);
    return_to_idle();
    close_test(err0);
  endtask

  task automatic run_mem_write();
    int          err0;
    int          sent;
    int          buf_left;
    int          strobes;
    int          cycles;
    logic        prev_stb;
    logic [31:0] w;
    err0     = errors;
    cur_test = "mem_write";
    for (int i = 0; i < N_WORDS; i++) begin
      take_random(32, w);
      shadow[BASE + i] = w;
    end
    sent     = 0;
    buf_left = 0;
    strobes  = 0;
    cycles   = 0;
    prev_stb = 1'b0;
    @(negedge clk);
    req = '{target: host_if_pkg::TGT_MEM, wr: 1'b1, rd: 1'b0, addr: BASE, count: N_WORDS};
    host_ing.data = expected_word(BASE);
    while (!write_fin && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      // a strobe seen last cycle popped the word on the bus
      if (prev_stb) begin
        sent++;
        buf_left--;
      end
      if (host_ing_ctl.act) begin
        host_ing.rdy = 1'b0;
      end else if (buf_left == 0 && sent < N_WORDS) begin
        buf_left      = (N_WORDS - sent < ING_SIZE) ? N_WORDS - sent : ING_SIZE;
        host_ing.rdy  = 1'b1;
        host_ing.size = buf_left;
      end
      host_ing.data = (sent < N_WORDS) ? expected_word(BASE + sent) : '0;
      prev_stb      = host_ing_ctl.stb;
      if (host_ing_ctl.stb) strobes++;
    end
    if (cycles >= TIMEOUT) report_fault("write finish never rose");
    if (strobes != N_WORDS) report_mismatch("strobe count", N_WORDS, strobes);
    return_to_idle();
    close_test(err0);
  endtask

  task automatic run_mem_read();
    int          err0;
    int          cycles;
    int          hold [`HOST_EGR_CH];
    logic [1:0]  taken;
    logic [1:0]  egr_rdy;
    logic [31:0] r;
    err0     = errors;
    cur_test = "mem_read";
    taken    = '0;
    egr_rdy  = '0;
    cycles   = 0;
    for (int ch = 0; ch < `HOST_EGR_CH; ch++) begin
      take_random(3, r);
      hold[ch] = r;
    end
    @(negedge clk);
    req = '{target: host_if_pkg::TGT_MEM, wr: 1'b0, rd: 1'b1, addr: BASE, count: N_WORDS};
    host_egr.size = EGR_SIZE;
    cmp_en        = 1'b1;
    while (!read_fin && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      // a returned buffer is held back for a random time
      for (int ch = 0; ch < `HOST_EGR_CH; ch++) begin
        if (host_egr_src.act[ch]) begin
          egr_rdy[ch] = 1'b0;
          taken[ch]   = 1'b1;
        end else if (taken[ch]) begin
          taken[ch] = 1'b0;
          take_random(3, r);
          hold[ch] = r;
        end else if (!egr_rdy[ch]) begin
          if (hold[ch] == 0) egr_rdy[ch] = 1'b1;
          else hold[ch]--;
        end
      end
      host_egr.rdy = egr_rdy;
    end
    if (cycles >= TIMEOUT) report_fault("read finish never rose");
    @(posedge clk);
    cmp_en = 1'b0;
    if (cmp_idx != N_WORDS) report_mismatch("word count", N_WORDS, cmp_idx);
    return_to_idle();
    close_test(err0);
  endtask

  task automatic run_dma_ingress();
    int          err0;
    logic [31:0] r;
    err0     = errors;
    cur_test = "dma_ingress";
    @(negedge clk);
    req = '{target: host_if_pkg::TGT_DMA, wr: 1'b1, rd: 1'b0, addr: 0, count: 0};
    for (int step = 0; step < 4; step++) begin
      take_random(25, r);
      host_ing.rdy  = r[24];
      host_ing.size = r[23:0];
      take_random(32, r);
      host_ing.data = r;
      dma_ing.act   = step[0] | step[1];
      dma_ing.stb   = step[0];
      dma_idle      = step[1];
      @(negedge clk);
      if (dma_ing_src !== host_ing) report_mismatch("dma ingress", host_ing, dma_ing_src);
      if (host_ing_ctl !== dma_ing) report_mismatch("host act/stb", dma_ing, host_ing_ctl);
      if (write_fin !== dma_idle) report_mismatch("write finish", dma_idle, write_fin);
    end
    return_to_idle();
    close_test(err0);
  endtask

  task automatic run_dma_read();
    int          err0;
    int          sent;
    logic [31:0] r;
    err0     = errors;
    cur_test = "dma_read";
    sent     = 0;
    @(negedge clk);
    req = '{target: host_if_pkg::TGT_DMA, wr: 1'b0, rd: 1'b1, addr: 0, count: DMA_CNT};
    dma_egr.act = 2'b01;
    // one strobe every other cycle
    for (int k = 0; k < 2 * DMA_CNT; k++) begin
      take_random(32, r);
      dma_egr.data = r;
      dma_egr.stb  = (k % 2 == 0);
      take_random(`HOST_EGR_CH + `HOST_FIFO_SIZE_W, r);
      host_egr     = r[`HOST_EGR_CH + `HOST_FIFO_SIZE_W - 1:0];
      if (dma_egr.stb) sent++;
      @(negedge clk);
      if (read_fin !== (sent >= DMA_CNT)) begin
        report_mismatch($sformatf("read finish after %0d strobes", sent),
                        sent >= DMA_CNT, read_fin);
      end
      if (host_egr_src !== dma_egr) begin
        report_mismatch("host egress act/stb/data", dma_egr, host_egr_src);
      end
      if (dma_egr_sink !== host_egr) begin
        report_mismatch("dma egress rdy/size", host_egr, dma_egr_sink);
      end
    end
    return_to_idle();
    close_test(err0);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    req      = '0;
    host_ing = '0;
    host_egr = '0;
    dma_ing  = '0;
    dma_egr  = '0;
    dma_idle = 1'b0;
    cmp_en   = 1'b0;
    lfsr     = 16'd61794;
    errors   = 0;
    tests    = 0;
    failed   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    run_mem_write();
    run_mem_read();
    run_dma_ingress();
    run_dma_read();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- word_mem.sv
/*
  word memory
  256 x 32 dual-port RAM, one write port and one registered read port
*/

`timescale 1ns/1ps
`include "host_if_consts.svh"

module word_mem (
  input  logic                    clk,
  input  logic                    i_wr_en,
  input  logic [`HOST_MEM_AW-1:0] i_wr_addr,
  input  logic [`HOST_DATA_W-1:0] i_wr_data,
  input  logic [`HOST_MEM_AW-1:0] i_rd_addr,
  output logic [`HOST_DATA_W-1:0] o_rd_data
);

  localparam int DEPTH = 1 << `HOST_MEM_AW;

  logic [`HOST_DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule
